// ==== rtl/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and instruction width
`define CPU_XLEN    32

// word address width of pc, imem and data memory
`define CPU_PC_W    11

// register file
`define CPU_NREGS   16
`define CPU_RADDR_W 4   // log2 of CPU_NREGS

// instruction queue depth, also the fetch credit count after reset
// power of two from 2 to 16
`define CPU_QDEPTH  4

`endif

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    // instruction bits 31:28
    typedef enum logic [3:0] {
        OP_MOV = 4'h0,  // rd = imm12
        OP_ADD = 4'h1,
        OP_SUB = 4'h2,
        OP_AND = 4'h3,
        OP_ORR = 4'h4,
        OP_EOR = 4'h5,
        OP_LSL = 4'h6,  // rd = rn << imm5
        OP_CMP = 4'h7,  // flags from rn - rm
        OP_STR = 4'h8,  // mem[rn + imm12] = rd
        OP_B   = 4'h9
    } opcode_e;

    // instruction bits 27:24, only tested by branches
    typedef enum logic [3:0] {
        COND_AL = 4'h0,
        COND_EQ = 4'h1,
        COND_NE = 4'h2,
        COND_MI = 4'h3,
        COND_PL = 4'h4,
        COND_CS = 4'h5,
        COND_CC = 4'h6,
        COND_VS = 4'h7,
        COND_VC = 4'h8
    } cond_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        FLUSH
    } ctrl_state_e;

endpackage: cpu_pkg

// ==== rtl/fetch_if.sv ====
`include "cpu_macros.svh"

interface fetch_if;

    // fetch to queue
    logic                 push;
    logic [`CPU_XLEN-1:0] push_instr;
    logic [`CPU_PC_W-1:0] push_pc;

    // queue to controller
    logic [`CPU_XLEN-1:0] pop_instr;
    logic [`CPU_PC_W-1:0] pop_pc;
    logic                 not_empty;

    // controller back to fetch and queue
    logic                 pop;    // also the credit return
    logic                 flush;  // taken branch

    modport producer (
        output push, push_instr, push_pc,
        input  pop, flush
    );

    modport buffer (
        input  push, push_instr, push_pc, pop, flush,
        output pop_instr, pop_pc, not_empty
    );

    modport consumer (
        output pop, flush,
        input  pop_instr, pop_pc, not_empty
    );

endinterface: fetch_if

// ==== rtl/fetch_unit.sv ====
`include "cpu_macros.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [`CPU_PC_W-1:0] start_pc,
    input  logic [`CPU_PC_W-1:0] branch_target,
    input  logic                 load_pc,
    output logic                 imem_req,
    output logic [`CPU_PC_W-1:0] imem_addr,
    input  logic [`CPU_XLEN-1:0] instr,
    input  logic                 instr_valid,
    fetch_if.producer            fq
);

    localparam int CW = $clog2(`CPU_QDEPTH + 1);

    logic [`CPU_PC_W-1:0] fetch_pc;
    logic [CW-1:0]        credits;  // free queue slots
    logic                 pending;  // request out, response not yet back
    logic                 discard;  // next response predates a flush
    logic                 pop_q;    // credit handed back last cycle
    logic                 issue;

    // one request at a time, never in a flush cycle
    assign issue = (credits != '0) && !pending && !imem_req && !fq.flush;

    assign fq.push       = instr_valid && !discard && !fq.flush;
    assign fq.push_instr = instr;
    assign fq.push_pc    = fetch_pc;
    assign imem_addr     = fetch_pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            imem_req <= 1'b0;
            pending  <= 1'b0;
            discard  <= 1'b0;
        end else begin
            imem_req <= issue;  // single cycle pulse
            if (instr_valid)
                pending <= 1'b0;
            else if (imem_req)
                pending <= 1'b1;
            if (fq.flush)
                discard <= imem_req || (pending && !instr_valid);
            else if (instr_valid)
                discard <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= start_pc;
            credits  <= CW'(`CPU_QDEPTH);
            pop_q    <= 1'b0;
        end else begin
            pop_q <= fq.pop && !fq.flush;
            if (fq.flush)
                credits <= CW'(`CPU_QDEPTH);  // queue is empty again
            else
                credits <= credits + CW'(pop_q) - CW'(fq.push);
            if (load_pc)
                fetch_pc <= branch_target;
            else if (fq.push)
                fetch_pc <= fetch_pc + 1'b1;
        end
    end

endmodule: fetch_unit

// ==== rtl/instr_queue.sv ====
`include "cpu_macros.svh"

module instr_queue (
    input  logic    clk,
    input  logic    arst_n,
    fetch_if.buffer fq
);

    localparam int AW = $clog2(`CPU_QDEPTH);

    logic [`CPU_XLEN-1:0] instr_mem [`CPU_QDEPTH];
    logic [`CPU_PC_W-1:0] pc_mem    [`CPU_QDEPTH];

    // extra top bit tells a full queue from an empty one
    logic [AW:0]          wr_ptr;
    logic [AW:0]          rd_ptr;
    logic [AW-1:0]        wr_idx;
    logic [AW-1:0]        rd_idx;

    assign wr_idx = wr_ptr[AW-1:0];
    assign rd_idx = rd_ptr[AW-1:0];

    // space is guaranteed by the fetch credits
    always_ff @(posedge clk) begin
        if (fq.push) begin
            instr_mem[wr_idx] <= fq.push_instr;
            pc_mem[wr_idx]    <= fq.push_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (fq.flush) begin
            // drop everything fetched past the branch
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fq.push)
                wr_ptr <= wr_ptr + 1'b1;
            if (fq.pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    assign fq.not_empty = (wr_ptr != rd_ptr);
    assign fq.pop_instr = instr_mem[rd_idx];  // head entry, read without delay
    assign fq.pop_pc    = pc_mem[rd_idx];

endmodule: instr_queue

// ==== rtl/controller.sv ====
`include "cpu_macros.svh"

module controller import cpu_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    fetch_if.consumer               fq,
    input  flags_t                  flags,
    output logic [`CPU_RADDR_W-1:0] rd,
    output logic [`CPU_RADDR_W-1:0] rn,
    output logic [`CPU_RADDR_W-1:0] rm,
    output logic [11:0]             imm12,
    output opcode_e                 alu_op,
    output logic                    sel_imm,
    output logic                    reg_w_en,
    output logic                    en_status,
    output logic                    mem_w_en,
    output logic                    load_pc,
    output logic [`CPU_PC_W-1:0]    branch_target
);

    ctrl_state_e          state;
    ctrl_state_e          state_next;
    logic [`CPU_XLEN-1:0] ex_instr;  // instruction in execute
    logic [`CPU_PC_W-1:0] ex_pc;
    logic                 exec;
    opcode_e              op;
    cond_e                cond;
    logic                 taken;

    function automatic logic cond_pass(cond_e c, flags_t f);
        logic pass;
        case (c)
            COND_AL: pass = 1'b1;
            COND_EQ: pass = f.z;
            COND_NE: pass = !f.z;
            COND_MI: pass = f.n;
            COND_PL: pass = !f.n;
            COND_CS: pass = f.c;
            COND_CC: pass = !f.c;
            COND_VS: pass = f.v;
            COND_VC: pass = !f.v;
            default: pass = 1'b0;  // unused codes never branch
        endcase
        return pass;
    endfunction

    assign exec = (state == ISSUE);
    assign op   = opcode_e'(ex_instr[31:28]);
    assign cond = cond_e'(ex_instr[27:24]);

    // ARM style field layout
    assign rd     = ex_instr[23:20];
    assign rn     = ex_instr[19:16];
    assign rm     = ex_instr[15:12];
    assign imm12  = ex_instr[11:0];
    assign alu_op = op;

    assign sel_imm   = (op == OP_MOV) || (op == OP_LSL) || (op == OP_STR);
    assign reg_w_en  = exec && (op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND,
                                           OP_ORR, OP_EOR, OP_LSL});
    assign en_status = exec && (op == OP_CMP);
    assign mem_w_en  = exec && (op == OP_STR);

    // flags already hold the result of a cmp issued just before
    assign taken    = exec && (op == OP_B) && cond_pass(cond, flags);
    assign load_pc  = taken;
    assign fq.flush = taken;

    // word offset from the branch's own pc
    assign branch_target = ex_pc + {{(`CPU_PC_W-8){ex_instr[7]}}, ex_instr[7:0]};

    // next pop overlaps the current execute, but never past a taken branch
    assign fq.pop = fq.not_empty && ((state == IDLE) || (exec && !taken));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (fq.not_empty)
                    state_next = ISSUE;
            end
            ISSUE: begin
                if (taken)
                    state_next = FLUSH;
                else if (!fq.not_empty)
                    state_next = IDLE;
            end
            FLUSH: state_next = IDLE;  // let the queue and pc settle
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (fq.pop) begin
            ex_instr <= fq.pop_instr;
            ex_pc    <= fq.pop_pc;
        end
    end

endmodule: controller

// ==== rtl/datapath.sv ====
`include "cpu_macros.svh"

module datapath import cpu_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`CPU_RADDR_W-1:0] rd,
    input  logic [`CPU_RADDR_W-1:0] rn,
    input  logic [`CPU_RADDR_W-1:0] rm,
    input  logic [11:0]             imm12,
    input  opcode_e                 alu_op,
    input  logic                    sel_imm,
    input  logic                    reg_w_en,
    input  logic                    en_status,
    input  logic [`CPU_RADDR_W-1:0] reg_addr,
    output flags_t                  flags,
    output logic [`CPU_XLEN-1:0]    datapath_out,
    output logic [`CPU_XLEN-1:0]    str_data,
    output logic [`CPU_XLEN-1:0]    reg_output
);

    logic [`CPU_XLEN-1:0]    regs [`CPU_NREGS];
    logic [`CPU_RADDR_W-1:0] b_addr;
    logic [`CPU_XLEN-1:0]    a;
    logic [`CPU_XLEN-1:0]    b_reg;
    logic [`CPU_XLEN-1:0]    b;
    logic [`CPU_XLEN-1:0]    sum;
    logic [`CPU_XLEN:0]      diff;    // top bit is the carry out
    logic [`CPU_XLEN-1:0]    shifted;
    logic [`CPU_XLEN-1:0]    result;
    flags_t                  cmp_flags;

    // str reads its data register through the second port
    assign b_addr = (alu_op == OP_STR) ? rd : rm;
    assign a      = regs[rn];
    assign b_reg  = regs[b_addr];
    assign b      = sel_imm ? {{(`CPU_XLEN-12){1'b0}}, imm12} : b_reg;

    assign sum     = a + b;
    assign diff    = {1'b0, a} + {1'b0, ~b} + 1'b1;  // carry set when no borrow
    assign shifted = a << b[4:0];                    // imm5 sits in imm12[4:0]

    always_comb begin
        case (alu_op)
            OP_MOV:         result = b;
            OP_ADD, OP_STR: result = sum;   // str address is rn + imm12
            OP_SUB, OP_CMP: result = diff[`CPU_XLEN-1:0];
            OP_AND:         result = a & b;
            OP_ORR:         result = a | b;
            OP_EOR:         result = a ^ b;
            OP_LSL:         result = shifted;
            default:        result = '0;
        endcase
    end

    assign cmp_flags.n = diff[`CPU_XLEN-1];
    assign cmp_flags.z = (diff[`CPU_XLEN-1:0] == '0);
    assign cmp_flags.c = diff[`CPU_XLEN];
    // operands of opposite sign and result sign differs from rn
    assign cmp_flags.v = (a[`CPU_XLEN-1] ^ b[`CPU_XLEN-1]) &
                         (diff[`CPU_XLEN-1] ^ a[`CPU_XLEN-1]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end else if (reg_w_en) begin
            regs[rd] <= result;
        end
    end

    // nzcv only changes on cmp
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            flags <= '0;
        else if (en_status)
            flags <= cmp_flags;
    end

    assign datapath_out = result;
    assign str_data     = b_reg;
    assign reg_output   = regs[reg_addr];  // debug port

endmodule: datapath

// ==== rtl/cpu.sv ====
`include "cpu_macros.svh"

module cpu import cpu_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`CPU_PC_W-1:0]    start_pc,
    input  logic [`CPU_XLEN-1:0]    instr,
    input  logic                    instr_valid,
    input  logic [`CPU_RADDR_W-1:0] reg_addr,
    output logic                    imem_req,
    output logic [`CPU_PC_W-1:0]    imem_addr,
    output logic                    mem_w_en,
    output logic [`CPU_PC_W-1:0]    ram_addr,
    output logic [`CPU_XLEN-1:0]    ram_in,
    output logic [`CPU_XLEN-1:0]    status,
    output logic [`CPU_XLEN-1:0]    dp_out,
    output logic [`CPU_PC_W-1:0]    pc,
    output logic                    load_pc,
    output logic [`CPU_XLEN-1:0]    reg_output
);

    // controller to datapath
    logic [`CPU_RADDR_W-1:0] rd;
    logic [`CPU_RADDR_W-1:0] rn;
    logic [`CPU_RADDR_W-1:0] rm;
    logic [11:0]             imm12;
    opcode_e                 alu_op;
    logic                    sel_imm;
    logic                    reg_w_en;
    logic                    en_status;
    logic [`CPU_PC_W-1:0]    branch_target;

    // datapath outputs
    flags_t                  flags;
    logic [`CPU_XLEN-1:0]    datapath_out;
    logic [`CPU_XLEN-1:0]    str_data;

    fetch_if fq ();

    fetch_unit fetch_unit (
        .clk           (clk),
        .arst_n        (arst_n),
        .start_pc      (start_pc),
        .branch_target (branch_target),
        .load_pc       (load_pc),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .fq            (fq.producer)
    );

    instr_queue instr_queue (
        .clk    (clk),
        .arst_n (arst_n),
        .fq     (fq.buffer)
    );

    controller controller (
        .clk           (clk),
        .arst_n        (arst_n),
        .fq            (fq.consumer),
        .flags         (flags),
        .rd            (rd),
        .rn            (rn),
        .rm            (rm),
        .imm12         (imm12),
        .alu_op        (alu_op),
        .sel_imm       (sel_imm),
        .reg_w_en      (reg_w_en),
        .en_status     (en_status),
        .mem_w_en      (mem_w_en),
        .load_pc       (load_pc),
        .branch_target (branch_target)
    );

    datapath datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .rd           (rd),
        .rn           (rn),
        .rm           (rm),
        .imm12        (imm12),
        .alu_op       (alu_op),
        .sel_imm      (sel_imm),
        .reg_w_en     (reg_w_en),
        .en_status    (en_status),
        .reg_addr     (reg_addr),
        .flags        (flags),
        .datapath_out (datapath_out),
        .str_data     (str_data),
        .reg_output   (reg_output)
    );

    assign status   = {flags, {(`CPU_XLEN-4){1'b0}}};  // nzcv in 31:28
    assign dp_out   = datapath_out;
    assign ram_addr = datapath_out[`CPU_PC_W-1:0];
    assign ram_in   = str_data;
    assign pc       = imem_addr;  // fetch pc

endmodule: cpu

// ==== sim/cpu_assertions.sv ====
`include "cpu_macros.svh"

module cpu_assertions (
    input logic                 clk,
    input logic                 arst_n,
    input logic [`CPU_PC_W-1:0] start_pc,
    input logic                 imem_req,
    input logic                 instr_valid,
    input logic                 mem_w_en,
    input logic [`CPU_PC_W-1:0] ram_addr,
    input logic [`CPU_XLEN-1:0] ram_in,
    input logic [`CPU_XLEN-1:0] dp_out,
    input logic [`CPU_XLEN-1:0] status,
    input logic [`CPU_PC_W-1:0] pc,
    input logic                 load_pc,
    input logic                 en_status,
    input logic                 push,
    input logic                 pop,
    input logic                 flush
);

    localparam logic [`CPU_PC_W-1:0] POISON_ADDR  = 11'h10F;  // str skipped by beq
    localparam logic [`CPU_PC_W-1:0] TAKEN_TARGET = 11'd17;   // beq at 15 with offset 2

    int          errors;     // watched by the testbench
    int          occupancy;  // pushes minus pops since the last flush
    int          cmp_idx;
    logic        req_pending;
    logic [3:0]  last_nzcv;
    logic [32:0] exp_store;  // known flag and value

    // expected store data per program address
    function automatic logic [32:0] store_expect(logic [`CPU_PC_W-1:0] addr);
        case (addr)
            11'h100: return {1'b1, 32'd7 + 32'd12};   // add r3
            11'h101: return {1'b1, 32'd12 - 32'd7};   // sub r4
            11'h102: return {1'b1, 32'd7 & 32'd12};   // and r5
            11'h103: return {1'b1, 32'd7 | 32'd12};   // orr r6
            11'h104: return {1'b1, 32'd7 ^ 32'd12};   // eor r7
            11'h105: return {1'b1, 32'd7 << 4};       // lsl r10
            11'h1FF: return {1'b1, 32'd12};           // done marker from r2
            default: return {1'b0, 32'd0};
        endcase
    endfunction

    // nzcv of rn - rm for each cmp in program order
    function automatic logic [3:0] nzcv_expect(int idx);
        case (idx)
            0:       return 4'b0110;  // 19 - 19 is zero with no borrow
            1:       return 4'b0110;
            2:       return 4'b1000;  // 7 - 12 goes negative with a borrow
            default: return 4'b0000;
        endcase
    endfunction

    assign exp_store = store_expect(ram_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupancy   <= 0;
            req_pending <= 1'b0;
            cmp_idx     <= 0;
            last_nzcv   <= 4'b0000;
        end else begin
            if (flush)
                occupancy <= 0;  // queue emptied
            else
                occupancy <= occupancy + int'(push) - int'(pop);
            if (instr_valid)
                req_pending <= 1'b0;
            else if (imem_req)
                req_pending <= 1'b1;
            if (en_status) begin
                cmp_idx   <= cmp_idx + 1;
                last_nzcv <= nzcv_expect(cmp_idx);
            end
        end
    end

    reset_values: assert property (@(posedge clk)
        !arst_n |-> !imem_req && !mem_w_en && !load_pc && status == '0)
        else begin
            $error("Error t=%0t reset imem_req=%b mem_w_en=%b load_pc=%b status=%h expected 0",
                   $time, imem_req, mem_w_en, load_pc, status);
            errors++;
        end

    reset_pc: assert property (@(posedge clk)
        !arst_n |-> pc == start_pc)
        else begin
            $error("Error t=%0t in reset pc=%h expected %h", $time, pc, start_pc);
            errors++;
        end

    no_poison_store: assert property (@(posedge clk) disable iff (!arst_n)
        mem_w_en |-> ram_addr != POISON_ADDR)
        else begin
            $error("Error t=%0t ram_addr=%h is the skipped store, expected no store there",
                   $time, ram_addr);
            errors++;
        end

    store_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
        mem_w_en |-> exp_store[32])
        else begin
            $error("Error t=%0t ram_addr=%h is not an address the program stores to",
                   $time, ram_addr);
            errors++;
        end

    // r8 plus any store offset of the program stays below 2048
    store_addr_full: assert property (@(posedge clk) disable iff (!arst_n)
        mem_w_en |-> dp_out == {{(`CPU_XLEN-`CPU_PC_W){1'b0}}, ram_addr})
        else begin
            $error("Error t=%0t dp_out=%h expected %h on a store",
                   $time, dp_out, {{(`CPU_XLEN-`CPU_PC_W){1'b0}}, ram_addr});
            errors++;
        end

    store_value: assert property (@(posedge clk) disable iff (!arst_n)
        mem_w_en && exp_store[32] |-> ram_in == exp_store[31:0])
        else begin
            $error("Error t=%0t ram_in=%h expected %h at ram_addr %h",
                   $time, ram_in, exp_store[31:0], ram_addr);
            errors++;
        end

    cmp_flags: assert property (@(posedge clk) disable iff (!arst_n)
        en_status |=> status[31:28] == last_nzcv)
        else begin
            $error("Error t=%0t status[31:28]=%b expected %b", $time, status[31:28], last_nzcv);
            errors++;
        end

    // only the beq is taken in this program
    branch_target: assert property (@(posedge clk) disable iff (!arst_n)
        load_pc |=> pc == TAKEN_TARGET)
        else begin
            $error("Error t=%0t pc=%h expected %h after load_pc", $time, pc, TAKEN_TARGET);
            errors++;
        end

    credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        occupancy >= 0 && occupancy <= `CPU_QDEPTH)
        else begin
            $error("Error t=%0t queue occupancy=%0d expected 0 to %0d",
                   $time, occupancy, `CPU_QDEPTH);
            errors++;
        end

    one_request: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req |-> !req_pending)
        else begin
            $error("Error t=%0t imem_req=1 while a request is pending, expected 0", $time);
            errors++;
        end

endmodule: cpu_assertions

// ==== sim/cpu_tb.sv ====
`include "cpu_macros.svh"

module cpu_tb import cpu_pkg::*; ();

    // about 40 instructions at 6 cycles each with ample margin
    localparam int                   CYCLE_LIMIT = 2000;
    localparam logic [`CPU_PC_W-1:0] DONE_ADDR   = 11'h1FF;

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic [`CPU_PC_W-1:0]    start_pc;
    logic [`CPU_XLEN-1:0]    instr;
    logic                    instr_valid;
    logic [`CPU_RADDR_W-1:0] reg_addr;
    logic                    imem_req;
    logic [`CPU_PC_W-1:0]    imem_addr;
    logic                    mem_w_en;
    logic [`CPU_PC_W-1:0]    ram_addr;
    logic [`CPU_XLEN-1:0]    ram_in;
    logic [`CPU_XLEN-1:0]    status;
    logic [`CPU_XLEN-1:0]    dp_out;
    logic [`CPU_PC_W-1:0]    pc;
    logic                    load_pc;
    logic [`CPU_XLEN-1:0]    reg_output;

    logic [`CPU_XLEN-1:0]    prog [1 << `CPU_PC_W];
    logic [`CPU_PC_W-1:0]    req_addr;
    int                      wait_cnt;
    int                      cycles;

    cpu i_dut (.*);

    bind cpu cpu_assertions i_cpu_assertions (
        .clk         (clk),
        .arst_n      (arst_n),
        .start_pc    (start_pc),
        .imem_req    (imem_req),
        .instr_valid (instr_valid),
        .mem_w_en    (mem_w_en),
        .ram_addr    (ram_addr),
        .ram_in      (ram_in),
        .dp_out      (dp_out),
        .status      (status),
        .pc          (pc),
        .load_pc     (load_pc),
        .en_status   (en_status),
        .push        (fq.push),
        .pop         (fq.pop),
        .flush       (fq.flush)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] encode(opcode_e op, cond_e cond, logic [3:0] rd,
                                           logic [3:0] rn, logic [3:0] rm, logic [11:0] imm);
        return {op, cond, rd, rn, rm, imm};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic load_program();
        // unused words load r15 with their own address
        for (int a = 0; a < (1 << `CPU_PC_W); a++)
            prog[a] = encode(OP_MOV, COND_AL, 4'd15, 4'd0, 4'd0, 12'(a));
        prog[0]  = encode(OP_MOV, COND_AL, 4'd1, 4'd0, 4'd0, 12'd7);
        prog[1]  = encode(OP_MOV, COND_AL, 4'd2, 4'd0, 4'd0, 12'd12);
        prog[2]  = encode(OP_ADD, COND_AL, 4'd3, 4'd1, 4'd2, 12'd0);
        prog[3]  = encode(OP_SUB, COND_AL, 4'd4, 4'd2, 4'd1, 12'd0);
        prog[4]  = encode(OP_AND, COND_AL, 4'd5, 4'd1, 4'd2, 12'd0);
        prog[5]  = encode(OP_ORR, COND_AL, 4'd6, 4'd1, 4'd2, 12'd0);
        prog[6]  = encode(OP_EOR, COND_AL, 4'd7, 4'd1, 4'd2, 12'd0);
        prog[7]  = encode(OP_MOV, COND_AL, 4'd8, 4'd0, 4'd0, 12'h100);  // store base
        for (int i = 0; i < 5; i++)
            prog[8+i] = encode(OP_STR, COND_AL, 4'(3 + i), 4'd8, 4'd0, 12'(i));
        prog[13] = encode(OP_MOV, COND_AL, 4'd9, 4'd0, 4'd0, 12'd19);
        prog[14] = encode(OP_CMP, COND_AL, 4'd0, 4'd3, 4'd9, 12'd0);
        prog[15] = encode(OP_B,   COND_EQ, 4'd0, 4'd0, 4'd0, 12'd2);   // taken to 17
        prog[16] = encode(OP_STR, COND_AL, 4'd1, 4'd8, 4'd0, 12'h00F); // poisoned
        prog[17] = encode(OP_CMP, COND_AL, 4'd0, 4'd9, 4'd3, 12'd0);
        prog[18] = encode(OP_B,   COND_NE, 4'd0, 4'd0, 4'd0, 12'd5);   // not taken
        prog[19] = encode(OP_LSL, COND_AL, 4'd10, 4'd1, 4'd0, 12'd4);
        prog[20] = encode(OP_STR, COND_AL, 4'd10, 4'd8, 4'd0, 12'd5);
        prog[21] = encode(OP_CMP, COND_AL, 4'd0, 4'd1, 4'd2, 12'd0);
        prog[22] = encode(OP_STR, COND_AL, 4'd2, 4'd8, 4'd0, 12'h0FF); // done marker
    endtask

    task automatic check_registers();
        logic [31:0] exp_regs [15];
        exp_regs     = '{default: 32'd0};
        exp_regs[1]  = 32'd7;
        exp_regs[2]  = 32'd12;
        exp_regs[3]  = exp_regs[1] + exp_regs[2];
        exp_regs[4]  = exp_regs[2] - exp_regs[1];
        exp_regs[5]  = exp_regs[1] & exp_regs[2];
        exp_regs[6]  = exp_regs[1] | exp_regs[2];
        exp_regs[7]  = exp_regs[1] ^ exp_regs[2];
        exp_regs[8]  = 32'h100;
        exp_regs[9]  = 32'd19;
        exp_regs[10] = exp_regs[1] << 4;
        for (int r = 0; r < 15; r++) begin  // r15 keeps changing after done
            @(posedge clk);
            reg_addr <= 4'(r);
            @(negedge clk);
            assert (reg_output == exp_regs[r])
                else stop_with_failure(
                    $sformatf("Error t=%0t reg_output=%h expected %h at reg_addr %0d",
                              $time, reg_output, exp_regs[r], r));
        end
    endtask

    // instruction memory answers one request at a time after a random wait
    always @(posedge clk) begin
        instr_valid <= 1'b0;
        if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
            if (wait_cnt == 1) begin
                instr       <= prog[req_addr];
                instr_valid <= 1'b1;
            end
        end else if (imem_req) begin
            req_addr <= imem_addr;
            wait_cnt <= int'($urandom_range(5, 1));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            stop_with_failure("timeout, no store to the done address within the cycle limit");
    end

    always @(negedge clk) begin
        if (i_dut.i_cpu_assertions.errors != 0)
            stop_with_failure("an assertion on the cpu failed");
    end

    initial begin
        void'($urandom(12721));
        load_program();
        arst_n      = 1'b0;
        start_pc    = '0;
        instr       = '0;
        instr_valid = 1'b0;
        reg_addr    = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        do
            @(negedge clk);
        while (!(mem_w_en && ram_addr == DONE_ADDR));
        check_registers();
        if (i_dut.i_cpu_assertions.errors == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("an assertion on the cpu failed");
        end
    end

endmodule: cpu_tb

// ==== flist.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/fetch_if.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
rtl/controller.sv
rtl/datapath.sv
rtl/cpu.sv
sim/cpu_assertions.sv
sim/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
